/* Makefile */
OBJDIR = obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module controllerTb \
		-f sayacController.f --Mdir $(OBJDIR) -o controllerTb

run: compile
	./$(OBJDIR)/controllerTb

clean:
	rm -rf $(OBJDIR)

/* sayacController.f */
+incdir+include
verilog/isaPkg.sv
verilog/ctrlPkg.sv
verilog/branchCondition.sv
verilog/instructionDecoder.sv
verilog/controlSequencer.sv
verilog/sayacController.sv
tests/controllerTb.sv

/* include/tbReference.svh */
// Testbench reference model for expected decode and branch outcome, plus the stimulus LFSR
`ifndef TB_REFERENCE_SVH
`define TB_REFERENCE_SVH

// 16-bit Galois LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsrStep(input logic [15:0] s);
	return {1'b0, s[15:1]} ^ (s[0] ? 16'hB400 : 16'h0000);
endfunction

// Expected branch outcome from the condition code and the two flags
function automatic bit refTaken(input isaPkg::fib_t f, input isaPkg::flags_t fl);
	bit eq;
	bit gt;
	eq = fl[isaPkg::flagEq];
	gt = fl[isaPkg::flagGt];
	case (f[2:0])
		3'd0: return eq;
		3'd1: return !gt;
		3'd2: return gt;
		3'd3: return gt || eq;
		3'd4: return !gt || eq;
		3'd5: return !eq;
		default: return 1'b0;
	endcase
endfunction

// Expected EXEC1 word for ALU, immediate and shift classes
function automatic ctrlPkg::ctrlWord_t refAluCtrl(input isaPkg::opcode_t op);
	ctrlPkg::ctrlWord_t c;
	isaPkg::majorOp_t major;
	major = isaPkg::majorOp_t'(op[7:4]);
	c = ctrlPkg::ctrlIdle;
	c.trf.wrSel = ctrlPkg::WR_RD0;
	c.trf.write = 1'b1;
	c.pc.src = ctrlPkg::PC_INC;
	c.pc.ldPc = 1'b1;
	case (major)
		isaPkg::ANR, isaPkg::ANI: c.trf.src = ctrlPkg::SRC_LOGIC;
		isaPkg::MSI, isaPkg::MHI: c.trf.src = ctrlPkg::SRC_IMM;
		isaPkg::SLR, isaPkg::SAR, isaPkg::EXT: c.trf.src = ctrlPkg::SRC_SHIFT;
		default: c.trf.src = ctrlPkg::SRC_ARITH;
	endcase
	case (major)
		isaPkg::ANR, isaPkg::ANI: c.ex.aluOp = ctrlPkg::ALU_AND;
		isaPkg::SLR: c.ex.aluOp = ctrlPkg::ALU_SHL;
		isaPkg::SAR: c.ex.aluOp = ctrlPkg::ALU_SHA;
		isaPkg::ADR, isaPkg::ADI: c.ex.aluOp = ctrlPkg::ALU_ADD;
		isaPkg::SUR, isaPkg::SUI: c.ex.aluOp = ctrlPkg::ALU_SUB;
		isaPkg::EXT: c.ex.aluOp = op[1] ? ctrlPkg::ALU_SHA : ctrlPkg::ALU_SHL;
		default: c.ex.aluOp = ctrlPkg::ALU_NONE;
	endcase
	case (major)
		isaPkg::ANI: c.ex.immKind = ctrlPkg::IMM_USE8;
		isaPkg::MSI, isaPkg::ADI, isaPkg::SUI: c.ex.immKind = ctrlPkg::IMM_SE8;
		isaPkg::MHI: c.ex.immKind = ctrlPkg::IMM_LOWBITS;
		default: c.ex.immKind = ctrlPkg::IMM_NONE;
	endcase
	return c;
endfunction

`endif

/* tests/controllerTb.sv */
// Testbench for the SAYAC controller, run the instruction mix and let the assertions check it
`timescale 1ns/1ps
`default_nettype none

module controllerTb;

	// About ten times the cycles the instruction mix needs
	localparam int cycleLimit = 4000;

	logic clk = 1'b0;
	logic rst;
	isaPkg::opcode_t opcode;
	isaPkg::flags_t outFlag;
	isaPkg::fib_t fib;
	logic readyMem;
	logic readyMdu;
	logic doneMdu;
	ctrlPkg::ctrlWord_t ctrl;

	logic [15:0] lfsrState;
	int cycleCount = 0;
	logic rstDly = 1'b1;
	logic prevLdIr;
	logic memWait;
	logic [1:0] mduStage;

	isaPkg::opcode_t opQ[$];
	isaPkg::fib_t fibQ[$];
	isaPkg::flags_t flagQ[$];

	`include "tbReference.svh"

	sayacController i_dut
	(
		.clk(clk),
		.rst(rst),
		.opcode(opcode),
		.outFlag(outFlag),
		.fib(fib),
		.readyMem(readyMem),
		.readyMdu(readyMdu),
		.doneMdu(doneMdu),
		.ctrl(ctrl)
	);

	always #10 clk = ~clk;

	task automatic failCheck(input string name, input logic [31:0] got, input logic [31:0] want);
		$display("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, want);
		$display("SOME TESTS FAILED");
		$fatal(1, "control word mismatch");
	endtask

	task automatic failRule(input string what);
		$display("Controller broke a rule: %s", what);
		$display("SOME TESTS FAILED");
		$fatal(1, "control sequence error");
	endtask

	// One LFSR step per bit taken
	task automatic drawBits(input int n, output logic [15:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsrState = lfsrStep(lfsrState);
			v = {v[14:0], lfsrState[0]};
		end
	endtask

	task automatic queueInstr(input isaPkg::opcode_t op, input isaPkg::fib_t f,
		input isaPkg::flags_t fl);
		opQ.push_back(op);
		fibQ.push_back(f);
		flagQ.push_back(fl);
	endtask

	task automatic buildProgram();
		logic [15:0] r;
		logic [15:0] lo;
		for (int i = 0; i < 40; i++)
		begin
			drawBits(4, r);
			if (r[3:0] >= 4'd3 && r[3:0] <= 4'd12)
			begin
				drawBits(4, lo);
				opQ.push_back({r[3:0], lo[3:0]});
			end
			else
			begin
				// Shift immediate, arithmetic when bit 1 is set
				drawBits(2, lo);
				opQ.push_back({6'b111110, lo[1:0]});
			end
			drawBits(8, lo);
			fibQ.push_back(5'd0);
			flagQ.push_back(lo[7:0]);
		end
		for (int i = 0; i < 8; i++)
		begin
			drawBits(2, lo);
			queueInstr(i[0] ? {6'b001001, lo[1:0]} : {6'b001000, lo[1:0]}, 5'd0, 8'h00);
			drawBits(4, lo);
			queueInstr(i[0] ? {4'hE, lo[3:0]} : {4'hD, lo[3:0]}, 5'd0, 8'h00);
		end
		// Every condition code against every eq and gt pair
		for (int c = 0; c < 8; c++)
			for (int fl = 0; fl < 4; fl++)
			begin
				queueInstr(8'hF4, 5'(c), 8'(fl << 4));
				queueInstr(8'hF6, 5'(c), 8'(fl << 4));
			end
		queueInstr(8'hF0, 5'd0, 8'h00);
		queueInstr(8'hF2, 5'd0, 8'h00);
	endtask

	// Instruction classes as the ISA encodes them
	function automatic bit isAluClass(input isaPkg::opcode_t op);
		return (op[7:4] >= 4'd3 && op[7:4] <= 4'd12) || op[7:2] == 6'b111110;
	endfunction

	logic aluExec;
	logic memClass;
	logic isLdr;
	logic brExec;
	logic cmpExec;
	logic isMul;
	logic mduExec1;
	ctrlPkg::ctrlWord_t expAlu;
	ctrlPkg::pcSrc_t expPcSrc;

	assign aluExec = prevLdIr && isAluClass(opcode);
	assign memClass = opcode[7:4] == 4'h2 && !opcode[3];
	assign isLdr = opcode[3:2] == 2'b00;
	assign brExec = prevLdIr && opcode[7:2] == 6'b111101;
	assign cmpExec = prevLdIr && opcode[7:2] == 6'b111100;
	assign isMul = opcode[7:4] == 4'hD;
	assign mduExec1 = (prevLdIr && (isMul || opcode[7:4] == 4'hE)) || mduStage == 2'd1;
	assign expAlu = refAluCtrl(opcode);
	assign expPcSrc = !refTaken(fib, outFlag) ? ctrlPkg::PC_INC :
		(opcode[1] ? ctrlPkg::PC_REG : ctrlPkg::PC_ADDER);

	always @(posedge clk)
		rstDly <= rst;

	// Phase tracking seen from outside the DUT
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			prevLdIr <= 1'b0;
			memWait <= 1'b0;
			mduStage <= 2'd0;
		end
		else
		begin
			prevLdIr <= ctrl.mem.ldIr;
			if (prevLdIr && memClass)
				memWait <= 1'b1;
			else if (memWait && readyMem)
				memWait <= 1'b0;
			if (mduExec1)
				mduStage <= doneMdu ? 2'd2 : 2'd1;
			else if (mduStage == 2'd2)
				mduStage <= 2'd3;
			else
				mduStage <= 2'd0;
		end
	end

	resetFetch: assert property (@(posedge clk) !rst && rstDly |-> ctrl.mem.ldIr && ctrl.mem.read
		&& !ctrl.trf.write && !ctrl.pc.ldPc && !ctrl.mem.write && !ctrl.mdu.start && !ctrl.ex.enFlag)
		else failRule("first cycle after reset is not a clean fetch");
	fetchOnce: assert property (@(posedge clk) disable iff (rst) ctrl.mem.ldIr |=> !ctrl.mem.ldIr)
		else failRule("ldIr held for two cycles");
	fetchAddr: assert property (@(posedge clk) disable iff (rst)
		ctrl.mem.ldIr |-> ctrl.mem.read && ctrl.mem.addrSel == ctrlPkg::ADDR_PC)
		else failRule("fetch does not read from the PC address");

	aluSrc: assert property (@(posedge clk) disable iff (rst)
		aluExec |-> ctrl.trf.src == expAlu.trf.src)
		else failCheck("ctrl.trf.src", 32'($sampled(ctrl.trf.src)), 32'($sampled(expAlu.trf.src)));
	aluOp: assert property (@(posedge clk) disable iff (rst)
		aluExec |-> ctrl.ex.aluOp == expAlu.ex.aluOp)
		else failCheck("ctrl.ex.aluOp", 32'($sampled(ctrl.ex.aluOp)), 32'($sampled(expAlu.ex.aluOp)));
	aluImm: assert property (@(posedge clk) disable iff (rst)
		aluExec |-> ctrl.ex.immKind == expAlu.ex.immKind)
		else failCheck("ctrl.ex.immKind", 32'($sampled(ctrl.ex.immKind)),
			32'($sampled(expAlu.ex.immKind)));
	aluShImm: assert property (@(posedge clk) disable iff (rst)
		aluExec |-> ctrl.ex.shImm == (opcode[7:4] == 4'hF))
		else failCheck("ctrl.ex.shImm", 32'($sampled(ctrl.ex.shImm)),
			32'($sampled(opcode[7:4] == 4'hF)));
	aluCommit: assert property (@(posedge clk) disable iff (rst) aluExec |->
		ctrl.trf.write == expAlu.trf.write && ctrl.trf.wrSel == expAlu.trf.wrSel
		&& ctrl.pc.ldPc == expAlu.pc.ldPc && ctrl.pc.src == expAlu.pc.src)
		else failRule("ALU instruction does not write rd0 and step the PC");
	aluNext: assert property (@(posedge clk) disable iff (rst) aluExec |=> ctrl.mem.ldIr)
		else failRule("no fetch after a single-cycle instruction");

	memSetup: assert property (@(posedge clk) disable iff (rst)
		prevLdIr && memClass |-> ctrl.mem.ldAdr)
		else failRule("memory access does not load the address register");
	memHold: assert property (@(posedge clk) disable iff (rst) memWait && !readyMem |->
		!ctrl.trf.write && !ctrl.pc.ldPc && ctrl.mem.addrSel == ctrlPkg::ADDR_ADR
		&& (isLdr ? ctrl.mem.read : ctrl.mem.write))
		else failRule("memory access not held while readyMem is low");
	memCommit: assert property (@(posedge clk) disable iff (rst) memWait && readyMem |->
		ctrl.pc.ldPc && ctrl.mem.addrSel == ctrlPkg::ADDR_ADR
		&& (isLdr ? (ctrl.mem.read && ctrl.trf.write) : ctrl.mem.write))
		else failRule("memory access did not commit with readyMem");
	memNext: assert property (@(posedge clk) disable iff (rst) memWait && readyMem |=> ctrl.mem.ldIr)
		else failRule("no fetch after a memory access");

	branchPc: assert property (@(posedge clk) disable iff (rst) brExec |-> ctrl.pc.src == expPcSrc)
		else failCheck("ctrl.pc.src", 32'($sampled(ctrl.pc.src)), 32'($sampled(expPcSrc)));
	branchBase: assert property (@(posedge clk) disable iff (rst)
		brExec && !opcode[1] |-> ctrl.pc.base == ctrlPkg::BASE_P1)
		else failRule("conditional branch does not add to read port 1");
	branchLd: assert property (@(posedge clk) disable iff (rst) brExec |-> ctrl.pc.ldPc)
		else failRule("branch does not load the PC");
	cmpFlag: assert property (@(posedge clk) disable iff (rst) cmpExec |-> ctrl.ex.enFlag)
		else failRule("compare does not enable the flag register");

	startGate: assert property (@(posedge clk) disable iff (rst) ctrl.mdu.start |-> readyMdu)
		else failRule("start raised while readyMdu is low");
	startGiven: assert property (@(posedge clk) disable iff (rst)
		mduExec1 && readyMdu |-> ctrl.mdu.start)
		else failRule("start withheld while readyMdu is high");
	mduSelect: assert property (@(posedge clk) disable iff (rst)
		mduExec1 |-> ctrl.mdu.op == (isMul ? ctrlPkg::MDU_MUL : ctrlPkg::MDU_DIV))
		else failRule("multiplier-divider given the wrong operation");
	mduIdle: assert property (@(posedge clk) disable iff (rst) mduExec1 && !doneMdu |->
		!ctrl.trf.write && !ctrl.pc.ldPc && !ctrl.mdu.ldLow && !ctrl.mdu.ldHigh)
		else failRule("write or load before doneMdu");
	mduLoad: assert property (@(posedge clk) disable iff (rst) mduExec1 && doneMdu |->
		(isMul ? ctrl.mdu.ldHigh : ctrl.mdu.ldLow))
		else failRule("wrong result half loaded with doneMdu");
	mduSrc1: assert property (@(posedge clk) disable iff (rst) mduStage == 2'd2 |->
		ctrl.trf.src == (isMul ? ctrlPkg::SRC_MDUHIGH : ctrlPkg::SRC_MDULOW))
		else failCheck("ctrl.trf.src", 32'($sampled(ctrl.trf.src)),
			32'($sampled(isMul) ? ctrlPkg::SRC_MDUHIGH : ctrlPkg::SRC_MDULOW));
	mduWrite1: assert property (@(posedge clk) disable iff (rst) mduStage == 2'd2 |->
		ctrl.trf.write && !ctrl.pc.ldPc
		&& ctrl.trf.wrSel == (isMul ? ctrlPkg::WR_RD1 : ctrlPkg::WR_RD0))
		else failRule("first result write has the wrong target or steps the PC");
	mduSrc2: assert property (@(posedge clk) disable iff (rst) mduStage == 2'd3 |->
		ctrl.trf.src == (isMul ? ctrlPkg::SRC_MDULOW : ctrlPkg::SRC_MDUHIGH))
		else failCheck("ctrl.trf.src", 32'($sampled(ctrl.trf.src)),
			32'($sampled(isMul) ? ctrlPkg::SRC_MDULOW : ctrlPkg::SRC_MDUHIGH));
	mduWrite2: assert property (@(posedge clk) disable iff (rst) mduStage == 2'd3 |->
		ctrl.trf.write && ctrl.pc.ldPc
		&& ctrl.trf.wrSel == (isMul ? ctrlPkg::WR_RD0 : ctrlPkg::WR_RD1))
		else failRule("second result write has the wrong target or no PC load");

	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= cycleLimit)
		begin
			$display("Timeout after %0d cycles, the instruction mix never finished", cycleCount);
			$display("SOME TESTS FAILED");
			$fatal(1, "timeout");
		end
	end

	initial
	begin
		logic [15:0] r;
		int idx;
		bit finished;
		rst = 1'b1;
		opcode = '0;
		outFlag = '0;
		fib = '0;
		readyMem = 1'b0;
		readyMdu = 1'b0;
		doneMdu = 1'b0;
		lfsrState = 16'd89;
		buildProgram();
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		idx = 0;
		finished = 1'b0;
		while (!finished)
		begin
			@(posedge clk);
			drawBits(1, r);
			readyMem <= r[0];
			drawBits(1, r);
			readyMdu <= r[0];
			drawBits(2, r);
			doneMdu <= &r[1:0];
			// New instruction once the IR is loaded
			if (ctrl.mem.ldIr)
			begin
				if (idx == opQ.size())
					finished = 1'b1;
				else
				begin
					opcode <= opQ[idx];
					fib <= fibQ[idx];
					outFlag <= flagQ[idx];
					idx++;
				end
			end
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

`default_nettype wire

/* verilog/branchCondition.sv */
// Branch outcome from the FIB condition code and the equal and greater flags
`timescale 1ns/1ps
`default_nettype none

module branchCondition
(
	input  wire isaPkg::fib_t   fib,
	input  wire isaPkg::flags_t outFlag,
	output logic                taken
);

	isaPkg::cond_t cond;
	logic eq;
	logic gt;

	assign cond = isaPkg::cond_t'(fib[2:0]);
	assign eq = outFlag[isaPkg::flagEq];
	assign gt = outFlag[isaPkg::flagGt];

	always_comb
	begin
		case (cond)
			isaPkg::EQ:
				taken = eq;
			isaPkg::LT:
				taken = !gt;
			isaPkg::GT:
				taken = gt;
			isaPkg::GE:
				taken = gt || eq;
			isaPkg::LE:
				taken = !gt || eq;
			isaPkg::NE:
				taken = !eq;
			// Codes 6 and 7 never branch
			default:
				taken = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

/* verilog/controlSequencer.sv */
// Phase register and next-phase rules, gating commits on memory and multiplier-divider status
`timescale 1ns/1ps
`default_nettype none

module controlSequencer
(
	input  wire                     clk,
	input  wire                     rst,
	input  wire ctrlPkg::waitKind_t waitKind,
	input  wire                     readyMem,
	input  wire                     readyMdu,
	input  wire                     doneMdu,
	input  wire ctrlPkg::ctrlWord_t rawCtrl,
	output ctrlPkg::phase_t         phase,
	output ctrlPkg::ctrlWord_t      ctrl
);

	ctrlPkg::phase_t nextPhase;
	logic memHold;
	logic mduWait;

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			phase <= ctrlPkg::FETCH;
		else
			phase <= nextPhase;
	end

	always_comb
	begin
		nextPhase = ctrlPkg::FETCH;
		case (phase)
			ctrlPkg::FETCH:
				nextPhase = ctrlPkg::EXEC1;
			ctrlPkg::EXEC1:
				case (waitKind)
					ctrlPkg::WAIT_MEM:
						nextPhase = ctrlPkg::EXEC2;
					ctrlPkg::WAIT_MDU:
						nextPhase = doneMdu ? ctrlPkg::EXEC2 : ctrlPkg::EXEC1;
					default:
						nextPhase = ctrlPkg::FETCH;
				endcase
			ctrlPkg::EXEC2:
				if (waitKind == ctrlPkg::WAIT_MDU)
					nextPhase = ctrlPkg::EXEC3;
				else if (waitKind == ctrlPkg::WAIT_MEM && !readyMem)
					nextPhase = ctrlPkg::EXEC2;
			default:
				nextPhase = ctrlPkg::FETCH;
		endcase
	end

	// Memory access not yet acknowledged
	assign memHold = (phase == ctrlPkg::EXEC2) && (waitKind == ctrlPkg::WAIT_MEM) && !readyMem;
	assign mduWait = (phase == ctrlPkg::EXEC1) && (waitKind == ctrlPkg::WAIT_MDU);

	always_comb
	begin
		ctrl = rawCtrl;
		// Read or write stays up while waiting
		if (memHold)
		begin
			ctrl.trf.write = 1'b0;
			ctrl.pc.ldPc = 1'b0;
		end
		if (mduWait)
		begin
			ctrl.mdu.start = rawCtrl.mdu.start & readyMdu;
			ctrl.mdu.ldLow = rawCtrl.mdu.ldLow & doneMdu;
			ctrl.mdu.ldHigh = rawCtrl.mdu.ldHigh & doneMdu;
		end
	end

endmodule

`default_nettype wire

/* verilog/ctrlPkg.sv */
// Controller-side types: phases, stall class and the packed control word sent to the datapath
`default_nettype none

package ctrlPkg;

	typedef enum logic [1:0] {FETCH, EXEC1, EXEC2, EXEC3} phase_t;

	// What an instruction may wait on
	typedef enum logic [1:0] {WAIT_NONE, WAIT_MEM, WAIT_MDU} waitKind_t;

	// Register file selects
	typedef enum logic {P1_RS1, P1_RD} p1Sel_t;
	typedef enum logic {P2_RS2, P2_RD} p2Sel_t;
	typedef enum logic {WR_RD0, WR_RD1} wrSel_t;
	typedef enum logic [2:0]
	{
		SRC_DATABUS, SRC_PCINC, SRC_LOGIC, SRC_SHIFT,
		SRC_ARITH, SRC_MDULOW, SRC_MDUHIGH, SRC_IMM
	} trfSrc_t;

	// PC path
	typedef enum logic [1:0] {PC_INC, PC_REG, PC_ADDER} pcSrc_t;
	typedef enum logic {BASE_P1, BASE_IMM} pcBase_t;

	// Execute path
	typedef enum logic {OP2_REG, OP2_IMM} op2Sel_t;
	typedef enum logic [2:0] {IMM_NONE, IMM_SE5, IMM_SE6, IMM_SE8, IMM_USE8, IMM_LOWBITS} immKind_t;
	typedef enum logic [2:0] {ALU_NONE, ALU_ADD, ALU_SUB, ALU_AND, ALU_SHL, ALU_SHA} aluOp_t;

	typedef enum logic {MDU_MUL, MDU_DIV} mduOp_t;
	typedef enum logic {ADDR_PC, ADDR_ADR} addrSel_t;

	typedef struct packed
	{
		p1Sel_t  p1Sel;
		p2Sel_t  p2Sel;
		wrSel_t  wrSel;
		trfSrc_t src;
		logic    write;
	} trfCtrl_t;

	typedef struct packed
	{
		pcSrc_t  src;
		pcBase_t base;
		logic    ldPc;
	} pcCtrl_t;

	typedef struct packed
	{
		op2Sel_t  op2Sel;
		logic     shImm;
		aluOp_t   aluOp;
		immKind_t immKind;
		logic     enFlag;
	} exCtrl_t;

	typedef struct packed
	{
		logic   start;
		mduOp_t op;
		logic   ldLow;
		logic   ldHigh;
	} mduCtrl_t;

	typedef struct packed
	{
		addrSel_t addrSel;
		logic     read;
		logic     write;
		logic     ldIr;
		logic     ldAdr;
	} memCtrl_t;

	typedef struct packed
	{
		trfCtrl_t trf;
		pcCtrl_t  pc;
		exCtrl_t  ex;
		mduCtrl_t mdu;
		memCtrl_t mem;
	} ctrlWord_t;

	// All strobes low, all selects at their first value
	localparam ctrlWord_t ctrlIdle = '0;

endpackage

`default_nettype wire

/* verilog/instructionDecoder.sv */
// Opcode by phase decode into the raw control word and stall class used by the sequencer
`timescale 1ns/1ps
`default_nettype none

module instructionDecoder
(
	input  wire isaPkg::opcode_t opcode,
	input  wire ctrlPkg::phase_t phase,
	input  wire                  taken,
	output ctrlPkg::ctrlWord_t   rawCtrl,
	output ctrlPkg::waitKind_t   waitKind
);

	isaPkg::majorOp_t  major;
	isaPkg::memJmpOp_t memOp;
	isaPkg::extOp_t    extOp;

	assign major = isaPkg::majorOp_t'(opcode[7:4]);
	assign memOp = isaPkg::memJmpOp_t'(opcode[3:2]);
	assign extOp = isaPkg::extOpOf(opcode);

	// Stall class follows the instruction, the sequencer picks the phase
	always_comb
	begin
		waitKind = ctrlPkg::WAIT_NONE;
		if (major == isaPkg::MEMJMP && (memOp == isaPkg::LDR || memOp == isaPkg::STR))
			waitKind = ctrlPkg::WAIT_MEM;
		else if (major == isaPkg::MUL || major == isaPkg::DIV)
			waitKind = ctrlPkg::WAIT_MDU;
	end

	always_comb
	begin
		rawCtrl = ctrlPkg::ctrlIdle;
		case (phase)
			ctrlPkg::FETCH:
			begin
				rawCtrl.mem.addrSel = ctrlPkg::ADDR_PC;
				rawCtrl.mem.read = 1'b1;
				rawCtrl.mem.ldIr = 1'b1;
			end
			ctrlPkg::EXEC1:
			begin
				// Single-cycle classes step the PC here
				rawCtrl.pc.ldPc = 1'b1;
				case (major)
					isaPkg::MEMJMP:
						case (memOp)
							isaPkg::LDR, isaPkg::STR:
							begin
								rawCtrl.trf.p1Sel = (memOp == isaPkg::LDR) ?
									ctrlPkg::P1_RS1 : ctrlPkg::P1_RD;
								rawCtrl.mem.ldAdr = 1'b1;
								rawCtrl.pc.ldPc = 1'b0;
							end
							isaPkg::JMR:
							begin
								rawCtrl.trf.p1Sel = ctrlPkg::P1_RS1;
								rawCtrl.pc.src = ctrlPkg::PC_ADDER;
								rawCtrl.trf.src = ctrlPkg::SRC_PCINC;
								// opcode[1] asks for the link write
								rawCtrl.trf.write = opcode[1];
							end
							default:
							begin
								rawCtrl.ex.immKind = ctrlPkg::IMM_SE6;
								rawCtrl.pc.base = ctrlPkg::BASE_IMM;
								rawCtrl.pc.src = ctrlPkg::PC_ADDER;
								rawCtrl.trf.src = ctrlPkg::SRC_PCINC;
								rawCtrl.trf.write = 1'b1;
							end
						endcase
					isaPkg::ANR, isaPkg::SLR, isaPkg::SAR, isaPkg::ADR, isaPkg::SUR:
					begin
						rawCtrl.trf.p1Sel = ctrlPkg::P1_RS1;
						rawCtrl.trf.p2Sel = ctrlPkg::P2_RS2;
						rawCtrl.trf.write = 1'b1;
					end
					isaPkg::ANI, isaPkg::ADI, isaPkg::SUI:
					begin
						rawCtrl.trf.p1Sel = ctrlPkg::P1_RD;
						rawCtrl.ex.op2Sel = ctrlPkg::OP2_IMM;
						rawCtrl.ex.immKind = (major == isaPkg::ANI) ?
							ctrlPkg::IMM_USE8 : ctrlPkg::IMM_SE8;
						rawCtrl.trf.write = 1'b1;
					end
					isaPkg::MSI, isaPkg::MHI:
					begin
						rawCtrl.trf.p1Sel = ctrlPkg::P1_RD;
						rawCtrl.ex.immKind = (major == isaPkg::MSI) ?
							ctrlPkg::IMM_SE8 : ctrlPkg::IMM_LOWBITS;
						rawCtrl.trf.write = 1'b1;
					end
					isaPkg::MUL, isaPkg::DIV:
					begin
						// Held until doneMdu, first result half latched then
						rawCtrl.pc.ldPc = 1'b0;
						rawCtrl.trf.p1Sel = ctrlPkg::P1_RS1;
						rawCtrl.trf.p2Sel = ctrlPkg::P2_RS2;
						rawCtrl.mdu.op = (major == isaPkg::MUL) ? ctrlPkg::MDU_MUL : ctrlPkg::MDU_DIV;
						rawCtrl.mdu.start = 1'b1;
						rawCtrl.mdu.ldHigh = (major == isaPkg::MUL);
						rawCtrl.mdu.ldLow = (major == isaPkg::DIV);
					end
					isaPkg::EXT:
						case (extOp)
							isaPkg::CMR:
							begin
								rawCtrl.trf.p1Sel = ctrlPkg::P1_RS1;
								rawCtrl.trf.p2Sel = ctrlPkg::P2_RD;
								rawCtrl.ex.enFlag = 1'b1;
							end
							isaPkg::CMI:
							begin
								rawCtrl.trf.p1Sel = ctrlPkg::P1_RD;
								rawCtrl.ex.op2Sel = ctrlPkg::OP2_IMM;
								rawCtrl.ex.immKind = ctrlPkg::IMM_SE5;
								rawCtrl.ex.enFlag = 1'b1;
							end
							isaPkg::BRC:
							begin
								rawCtrl.trf.p1Sel = ctrlPkg::P1_RD;
								rawCtrl.pc.src = taken ? ctrlPkg::PC_ADDER : ctrlPkg::PC_INC;
							end
							isaPkg::BRR:
							begin
								rawCtrl.trf.p1Sel = ctrlPkg::P1_RD;
								rawCtrl.pc.src = taken ? ctrlPkg::PC_REG : ctrlPkg::PC_INC;
							end
							isaPkg::SHI:
							begin
								rawCtrl.trf.p1Sel = ctrlPkg::P1_RD;
								rawCtrl.ex.shImm = 1'b1;
								rawCtrl.trf.write = 1'b1;
							end
							default:
								rawCtrl.pc.src = ctrlPkg::PC_INC;
						endcase
					default:
						rawCtrl.pc.src = ctrlPkg::PC_INC;
				endcase
				// Operation and write source per class
				case (major)
					isaPkg::ANR, isaPkg::ANI:
					begin
						rawCtrl.ex.aluOp = ctrlPkg::ALU_AND;
						rawCtrl.trf.src = ctrlPkg::SRC_LOGIC;
					end
					isaPkg::MSI, isaPkg::MHI:
						rawCtrl.trf.src = ctrlPkg::SRC_IMM;
					isaPkg::SLR, isaPkg::SAR:
					begin
						rawCtrl.ex.aluOp = (major == isaPkg::SLR) ? ctrlPkg::ALU_SHL : ctrlPkg::ALU_SHA;
						rawCtrl.trf.src = ctrlPkg::SRC_SHIFT;
					end
					isaPkg::ADR, isaPkg::ADI, isaPkg::SUR, isaPkg::SUI:
					begin
						rawCtrl.ex.aluOp = (major == isaPkg::ADR || major == isaPkg::ADI) ?
							ctrlPkg::ALU_ADD : ctrlPkg::ALU_SUB;
						rawCtrl.trf.src = ctrlPkg::SRC_ARITH;
					end
					isaPkg::EXT:
						if (extOp == isaPkg::SHI)
						begin
							// opcode[1] picks the arithmetic shift
							rawCtrl.ex.aluOp = opcode[1] ? ctrlPkg::ALU_SHA : ctrlPkg::ALU_SHL;
							rawCtrl.trf.src = ctrlPkg::SRC_SHIFT;
						end
					default:
						rawCtrl.ex.aluOp = ctrlPkg::ALU_NONE;
				endcase
			end
			ctrlPkg::EXEC2:
				case (major)
					isaPkg::MEMJMP:
					begin
						rawCtrl.mem.addrSel = ctrlPkg::ADDR_ADR;
						rawCtrl.pc.ldPc = 1'b1;
						if (memOp == isaPkg::LDR)
						begin
							rawCtrl.mem.read = 1'b1;
							rawCtrl.trf.src = ctrlPkg::SRC_DATABUS;
							rawCtrl.trf.write = 1'b1;
						end
						else
						begin
							// Store data comes out on read port 1
							rawCtrl.trf.p1Sel = ctrlPkg::P1_RS1;
							rawCtrl.mem.write = 1'b1;
						end
					end
					isaPkg::MUL:
					begin
						rawCtrl.trf.wrSel = ctrlPkg::WR_RD1;
						rawCtrl.trf.src = ctrlPkg::SRC_MDUHIGH;
						rawCtrl.trf.write = 1'b1;
						rawCtrl.mdu.ldLow = 1'b1;
					end
					isaPkg::DIV:
					begin
						rawCtrl.trf.src = ctrlPkg::SRC_MDULOW;
						rawCtrl.trf.write = 1'b1;
						rawCtrl.mdu.op = ctrlPkg::MDU_DIV;
						rawCtrl.mdu.ldHigh = 1'b1;
					end
					default:
						rawCtrl.trf.write = 1'b0;
				endcase
			default:
				if (major == isaPkg::MUL || major == isaPkg::DIV)
				begin
					// Second half of the product or the remainder
					rawCtrl.trf.wrSel = (major == isaPkg::MUL) ? ctrlPkg::WR_RD0 : ctrlPkg::WR_RD1;
					rawCtrl.trf.src = (major == isaPkg::MUL) ?
						ctrlPkg::SRC_MDULOW : ctrlPkg::SRC_MDUHIGH;
					rawCtrl.trf.write = 1'b1;
					rawCtrl.pc.ldPc = 1'b1;
				end
		endcase
	end

endmodule

`default_nettype wire

/* verilog/isaPkg.sv */
// Instruction-set encodings shared by the decoder, the branch logic and the testbench model
`default_nettype none

package isaPkg;

	// Opcode byte as held in the instruction register
	typedef logic [7:0] opcode_t;

	// Major class in opcode[7:4]
	typedef enum logic [3:0]
	{
		RSV1, RSV2, MEMJMP, ANR,
		ANI, MSI, MHI, SLR,
		SAR, ADR, SUR, ADI,
		SUI, MUL, DIV, EXT
	} majorOp_t;

	// Memory and jump subclass in opcode[3:2]
	typedef enum logic [1:0]
	{
		LDR, STR, JMR, JMI
	} memJmpOp_t;

	// Extended subclass in opcode[3:1]
	typedef enum logic [2:0]
	{
		CMR = 3'b000,
		CMI = 3'b001,
		BRC = 3'b010,
		BRR = 3'b011,
		SHI = 3'b100,
		NOP = 3'b110
	} extOp_t;

	// Flag register and the two bits that branches test
	typedef logic [7:0] flags_t;
	localparam int flagEq = 4;
	localparam int flagGt = 5;

	// Branch field, condition code in the low three bits
	typedef logic [4:0] fib_t;
	typedef enum logic [2:0] {EQ, LT, GT, GE, LE, NE} cond_t;

	// Subclass of an EXT opcode
	function automatic extOp_t extOpOf(input opcode_t op);
		extOp_t ext;
		case (op[3:2])
			// Shift immediate covers 100 and 101
			2'b10: ext = SHI;
			// Old NTR and NTD codes only step the PC
			2'b11: ext = NOP;
			default: ext = extOp_t'(op[3:1]);
		endcase
		return ext;
	endfunction

endpackage

`default_nettype wire

/* verilog/sayacController.sv */
// SAYAC controller top, joining branch check, decoder and sequencer toward the datapath
`timescale 1ns/1ps
`default_nettype none

module sayacController
(
	input  wire                  clk,
	input  wire                  rst,
	input  wire isaPkg::opcode_t opcode,
	input  wire isaPkg::flags_t  outFlag,
	input  wire isaPkg::fib_t    fib,
	input  wire                  readyMem,
	input  wire                  readyMdu,
	input  wire                  doneMdu,
	output ctrlPkg::ctrlWord_t   ctrl
);

	logic               taken;
	ctrlPkg::phase_t    phase;
	ctrlPkg::ctrlWord_t rawCtrl;
	ctrlPkg::waitKind_t waitKind;

	branchCondition branchCheck
	(
		.fib(fib),
		.outFlag(outFlag),
		.taken(taken)
	);

	instructionDecoder decoder
	(
		.opcode(opcode),
		.phase(phase),
		.taken(taken),
		.rawCtrl(rawCtrl),
		.waitKind(waitKind)
	);

	controlSequencer sequencer
	(
		.clk(clk),
		.rst(rst),
		.waitKind(waitKind),
		.readyMem(readyMem),
		.readyMdu(readyMdu),
		.doneMdu(doneMdu),
		.rawCtrl(rawCtrl),
		.phase(phase),
		.ctrl(ctrl)
	);

endmodule

`default_nettype wire
